/* rtl/mem_cfg_pkg.sv */
// Size constants of the two-port banked memory
// Imported by the type package and by any RTL that slices address fields
package mem_cfg_pkg;

  localparam int WIDTH   = 32;               // Data word
  localparam int NUMVBNK = 4;                // Virtual banks seen by the address
  localparam int BITVBNK = 2;
  localparam int NUMPBNK = NUMVBNK + 1;      // One spare bank per row
  localparam int BITPBNK = 3;

  // Row field limit; the real row count is a top-level parameter
  localparam int MAXVROW = 64;
  localparam int BITVROW = 6;

  localparam int BITADDR = BITVROW + BITVBNK; // Bank in the low bits, row above

endpackage

/* rtl/mem_types_pkg.sv */
// Packed request, response and bank map types of the two-port memory
// Shared by the RTL and the testbench
package mem_types_pkg;

  import mem_cfg_pkg::*;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITPBNK-1:0] pbnk_t;

  typedef struct packed {
    logic               rd;
    logic               wr;
    logic [BITADDR-1:0] addr;
    word_t              data;
  } port_req_t;

  typedef struct packed {
    logic  valid;
    word_t data;
  } port_rsp_t;

  typedef struct packed {
    pbnk_t [NUMVBNK-1:0] pbnk; // Physical bank holding each virtual bank
    pbnk_t               free;
  } map_row_t;

  // Bank and row one port uses in the current cycle
  typedef struct packed {
    pbnk_t              pbnk;
    logic [BITVROW-1:0] row;
    logic               rd;
    logic               wr;
  } bank_sel_t;

endpackage

/* rtl/mem_array.sv */
`timescale 1ns/10ps
// Register array with two combinational reads and one clocked write
// Used for the bank map and for every data bank
module mem_array #(
  parameter type T       = logic [31:0],
  parameter int  DEPTH   = 16,
  localparam int AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic          clk,
  input  logic [AW-1:0] raddr0,
  input  logic [AW-1:0] raddr1,
  output T              rdata0,
  output T              rdata1,
  input  logic          we,
  input  logic [AW-1:0] waddr,
  input  T              wdata
);

  T mem [DEPTH];

  // Reads see the contents before this edge's write
  assign rdata0 = mem[raddr0];
  assign rdata1 = mem[raddr1];

  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
  end

endmodule

/* rtl/bank_map.sv */
`timescale 1ns/10ps
// Per-row map from virtual to physical banks, filled with identity rows after reset
// Sends port 1 to the row's free bank when both ports write one physical bank
module bank_map #(
  parameter int NUMVROW = 16
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  mem_types_pkg::port_req_t req0,
  input  mem_types_pkg::port_req_t req1,
  output mem_types_pkg::bank_sel_t sel0,
  output mem_types_pkg::bank_sel_t sel1,
  output logic                     ready
);

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  localparam int AW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  logic [AW-1:0]      swp_cnt;
  logic [BITVBNK-1:0] vbnk0;
  logic [BITVBNK-1:0] vbnk1;
  logic [BITVROW-1:0] vrow0;
  logic [BITVROW-1:0] vrow1;
  map_row_t           map0;
  map_row_t           map1;
  map_row_t           ident_row;
  map_row_t           remap_row;
  map_row_t           map_wdata;
  logic [AW-1:0]      map_waddr;
  logic               map_we;
  pbnk_t              pbnk0;
  pbnk_t              pbnk1;
  logic               wr_clash;

  assign vbnk0 = req0.addr[BITVBNK-1:0];
  assign vbnk1 = req1.addr[BITVBNK-1:0];
  assign vrow0 = req0.addr[BITADDR-1:BITVBNK];
  assign vrow1 = req1.addr[BITADDR-1:BITVBNK];

  mem_array #(
    .T     (map_row_t),
    .DEPTH (NUMVROW)
  ) u_map_mem (
    .clk    (clk),
    .raddr0 (vrow0[AW-1:0]),
    .raddr1 (vrow1[AW-1:0]),
    .rdata0 (map0),
    .rdata1 (map1),
    .we     (map_we),
    .waddr  (map_waddr),
    .wdata  (map_wdata)
  );

  // Reset sweep writes one row per cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      swp_cnt <= '0;
      ready   <= 1'b0;
    end
    else if (!ready)
    begin
      swp_cnt <= swp_cnt + 1'b1;
      if (swp_cnt == AW'(NUMVROW - 1))
        ready <= 1'b1;         // Last row written at this edge
    end
  end

  always_comb
  begin
    for (int v = 0; v < NUMVBNK; v++)
      ident_row.pbnk[v] = BITPBNK'(v);
    ident_row.free = BITPBNK'(NUMVBNK); // Spare bank starts free
  end

  assign pbnk0    = map0.pbnk[vbnk0];
  assign pbnk1    = map1.pbnk[vbnk1];
  assign wr_clash = ready && req0.wr && req1.wr && (pbnk0 == pbnk1);

  // Port 1 takes the free bank and the bank it leaves becomes free.
  // Port 0 never remaps, so a same-row pair still needs only this one row write.
  always_comb
  begin
    remap_row             = map1;
    remap_row.pbnk[vbnk1] = map1.free;
    remap_row.free        = pbnk1;
  end

  assign map_we    = !ready || wr_clash;
  assign map_waddr = ready ? vrow1[AW-1:0] : swp_cnt;
  assign map_wdata = ready ? remap_row : ident_row;

  always_comb
  begin
    sel0.pbnk = pbnk0;
    sel0.row  = vrow0;
    sel0.rd   = ready && req0.rd;
    sel0.wr   = ready && req0.wr;
    sel1.pbnk = wr_clash ? map1.free : pbnk1;
    sel1.row  = vrow1;
    sel1.rd   = ready && req1.rd;
    sel1.wr   = ready && req1.wr;
  end

endmodule

/* rtl/bank_datapath.sv */
`timescale 1ns/10ps
// Physical data banks of the two-port memory with write steering and read registers
// Driven by the bank selections that the bank map computes each cycle
module bank_datapath #(
  parameter int NUMVROW = 16
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  mem_types_pkg::bank_sel_t sel0,
  input  mem_types_pkg::bank_sel_t sel1,
  input  mem_types_pkg::port_req_t req0,
  input  mem_types_pkg::port_req_t req1,
  output mem_types_pkg::port_rsp_t rsp0,
  output mem_types_pkg::port_rsp_t rsp1
);

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  localparam int AW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  word_t bank_rd0 [NUMPBNK];
  word_t bank_rd1 [NUMPBNK];

  for (genvar b = 0; b < NUMPBNK; b++)
  begin : g_bank
    logic          hit0;
    logic          hit1;
    logic [AW-1:0] waddr;
    word_t         wdata;

    assign hit0  = sel0.wr && (sel0.pbnk == BITPBNK'(b));
    assign hit1  = sel1.wr && (sel1.pbnk == BITPBNK'(b));
    assign waddr = hit1 ? sel1.row[AW-1:0] : sel0.row[AW-1:0]; // At most one hit per bank
    assign wdata = hit1 ? req1.data : req0.data;

    mem_array #(
      .T     (word_t),
      .DEPTH (NUMVROW)
    ) u_bank (
      .clk    (clk),
      .raddr0 (sel0.row[AW-1:0]),
      .raddr1 (sel1.row[AW-1:0]),
      .rdata0 (bank_rd0[b]),
      .rdata1 (bank_rd1[b]),
      .we     (hit0 || hit1),
      .waddr  (waddr),
      .wdata  (wdata)
    );
  end

  // Old data is captured at the edge that also writes
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rsp0 <= '0;
      rsp1 <= '0;
    end
    else
    begin
      rsp0.valid <= sel0.rd;
      rsp1.valid <= sel1.rd;
      if (sel0.rd)
        rsp0.data <= bank_rd0[sel0.pbnk];
      if (sel1.rd)
        rsp1.data <= bank_rd1[sel1.pbnk];
    end
  end

endmodule

/* rtl/mem2rw_top.sv */
`timescale 1ns/10ps
// Two read/write port memory built from banks with two reads and one write each
// Requests count only while ready is high; reads answer one cycle later
module mem2rw_top #(
  parameter int NUMVROW = 16    // At most MAXVROW
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  mem_types_pkg::port_req_t req0,
  input  mem_types_pkg::port_req_t req1,
  output mem_types_pkg::port_rsp_t rsp0,
  output mem_types_pkg::port_rsp_t rsp1,
  output logic                     ready
);

  import mem_types_pkg::*;

  bank_sel_t sel0;
  bank_sel_t sel1;

  bank_map #(
    .NUMVROW (NUMVROW)
  ) u_map (
    .clk    (clk),
    .arst_n (arst_n),
    .req0   (req0),
    .req1   (req1),
    .sel0   (sel0),
    .sel1   (sel1),
    .ready  (ready)
  );

  bank_datapath #(
    .NUMVROW (NUMVROW)
  ) u_dp (
    .clk    (clk),
    .arst_n (arst_n),
    .sel0   (sel0),
    .sel1   (sel1),
    .req0   (req0),
    .req1   (req1),
    .rsp0   (rsp0),
    .rsp1   (rsp1)
  );

endmodule

/* tb/mem2rw_sva.sv */
`timescale 1ns/10ps
// Protocol and bank exclusivity assertions bound into every mem2rw_top instance
module mem2rw_sva (
  input logic                     clk,
  input logic                     arst_n,
  input mem_types_pkg::port_req_t req0,
  input mem_types_pkg::port_req_t req1,
  input mem_types_pkg::port_rsp_t rsp0,
  input mem_types_pkg::port_rsp_t rsp1,
  input logic                     ready,
  input mem_types_pkg::bank_sel_t sel0,
  input mem_types_pkg::bank_sel_t sel1
);

  int fails = 0;

  ready_holds: assert property (@(posedge clk) disable iff (!arst_n) ready |=> ready)
    else
    begin
      fails++;
      $error("ready fell after the reset sweep");
    end

  valid0_follows: assert property (@(posedge clk) disable iff (!arst_n)
    rsp0.valid == $past(ready && req0.rd))
    else
    begin
      fails++;
      $error("rsp0.valid does not follow an accepted read by one cycle");
    end

  valid1_follows: assert property (@(posedge clk) disable iff (!arst_n)
    rsp1.valid == $past(ready && req1.rd))
    else
    begin
      fails++;
      $error("rsp1.valid does not follow an accepted read by one cycle");
    end

  quiet_in_sweep: assert property (@(posedge clk) disable iff (!arst_n)
    !ready |-> !rsp0.valid && !rsp1.valid)
    else
    begin
      fails++;
      $error("response while ready is low");
    end

  // Each bank has a single write port
  bank_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    sel0.wr && sel1.wr |-> sel0.pbnk != sel1.pbnk)
    else
    begin
      fails++;
      $error("both ports write physical bank %0d", sel0.pbnk);
    end

endmodule

bind mem2rw_top mem2rw_sva u_sva (.*);

/* tb/mem2rw_tb.sv */
`timescale 1ns/10ps
// Testbench of the two-port banked memory with reset sweep, directed table and random traffic
// Random reads are checked against a shadow copy of the memory contents
module mem2rw_tb;

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  localparam int NUMVROW = 16;
  localparam int NUMADDR = NUMVROW * NUMVBNK;
  localparam int NRAND   = 400;

  typedef struct packed {
    port_req_t r0;
    port_req_t r1;
    logic      ev0;
    word_t     ed0;
    logic      ev1;
    word_t     ed1;
  } step_t;

  logic      clk;
  logic      arst_n;
  port_req_t req0;
  port_req_t req1;
  port_rsp_t rsp0;
  port_rsp_t rsp1;
  logic      ready;
  step_t     steps [$];
  word_t     shadow [NUMADDR];
  int        errors;
  int        checks;
  int        cycles;
  int        limit;
  int        seed;

  mem2rw_top #(
    .NUMVROW (NUMVROW)
  ) DUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    cycles = 0;
    do
      @(posedge clk) cycles++;
    while (cycles <= limit);
    $display("Run stopped after %0d cycles without reaching the end of the tests", cycles);
    $display("Verification failed");
    $finish;
  end

  function automatic word_t fill_word(input int a);
    return {8'hc3, 8'(a), 8'(a * 37), 8'(~a)};    // Distinct for every address
  endfunction

  function automatic port_req_t rd_req(input int a);
    return '{1'b1, 1'b0, BITADDR'(a), '0};
  endfunction

  function automatic port_req_t wr_req(input int a, input word_t d);
    return '{1'b0, 1'b1, BITADDR'(a), d};
  endfunction

  function automatic port_req_t random_req();
    int op;
    op = $unsigned($random(seed)) % 3;
    return '{op == 1, op == 2, BITADDR'($unsigned($random(seed)) % NUMADDR), $random(seed)};
  endfunction

  task automatic check_port(input string name, input port_rsp_t got, input logic ev,
                            input word_t ed);
    checks++;
    assert (got.valid === ev && (!ev || got.data === ed))
    else
    begin
      errors++;
      $display("FAIL %0t %s expected valid %b data %h, got valid %b data %h",
               $time, name, ev, ed, got.valid, got.data);
    end
  endtask

  // Applies one request cycle and samples the responses 1 ns after the accepting edge
  task automatic run_step(input step_t s);
    req0 = s.r0;
    req1 = s.r1;
    if (s.r0.wr)
      shadow[s.r0.addr] = s.r0.data;
    if (s.r1.wr)
      shadow[s.r1.addr] = s.r1.data;    // Port 1 wins a shared address
    @(posedge clk);
    #1;
    check_port("rsp0", rsp0, s.ev0, s.ed0);
    check_port("rsp1", rsp1, s.ev1, s.ed1);
  endtask

  task automatic reset_sweep();
    int n;
    n = 0;
    arst_n = 1'b0;
    repeat (16)
      @(posedge clk);
    #1;
    arst_n = 1'b1;
    while (!ready)
    begin
      req0 = wr_req(n, 32'hdead_0000 + n);
      req1 = (n % 2) ? wr_req(n + 16, 32'hbeef_0000 + n) : rd_req(n + 16); // Same bank as req0
      @(posedge clk);
      #1;
      check_port("rsp0", rsp0, 1'b0, '0);
      check_port("rsp1", rsp1, 1'b0, '0);
      n++;
    end
    checks++;
    assert (n == NUMVROW)
    else
    begin
      errors++;
      $display("FAIL %0t ready delay expected %0d got %0d cycles", $time, NUMVROW, n);
    end
    req0 = '0;
    req1 = '0;
  endtask

  task automatic add_step(input port_req_t r0, input port_req_t r1, input logic ev0,
                          input word_t ed0, input logic ev1, input word_t ed1);
    steps.push_back(step_t'{r0, r1, ev0, ed0, ev1, ed1});
  endtask

  task automatic random_phase();
    step_t s;
    repeat (NRAND)
    begin
      s.r0  = random_req();
      s.r1  = random_req();
      s.ev0 = s.r0.rd;
      s.ed0 = shadow[s.r0.addr];
      s.ev1 = s.r1.rd;
      s.ed1 = shadow[s.r1.addr];
      run_step(s);
    end
  endtask

  initial
  begin
    seed   = 32'hef8e;
    errors = 0;
    checks = 0;
    arst_n = 1'b0;
    req0   = '0;
    req1   = '0;
    add_step(rd_req('h00), rd_req('h11), 1, fill_word('h00), 1, fill_word('h11));
    add_step(wr_req('h20, 32'h1111_0020), wr_req('h25, 32'h2222_0025), 0, '0, 0, '0);
    add_step(rd_req('h25), rd_req('h20), 1, 32'h2222_0025, 1, 32'h1111_0020);
    add_step(wr_req('h30, 32'ha300_0030), wr_req('h34, 32'hb300_0034), 0, '0, 0, '0);
    add_step(rd_req('h34), rd_req('h30), 1, 32'hb300_0034, 1, 32'ha300_0030);
    add_step(wr_req('h3c, 32'hc000_003c), wr_req('h3c, 32'hc111_003c), 0, '0, 0, '0);
    add_step(rd_req('h3c), wr_req('h3c, 32'hd111_003c), 1, 32'hc111_003c, 0, '0);
    add_step(wr_req('h3c, 32'hd000_003c), rd_req('h3c), 0, '0, 1, 32'hd111_003c);
    add_step(rd_req('h3c), rd_req('h3c), 1, 32'hd000_003c, 1, 32'hd000_003c);
    // Four collisions in row 2 move the free bank on each time
    add_step(wr_req('h08, 32'he000_0008), wr_req('h08, 32'he111_0008), 0, '0, 0, '0);
    add_step(wr_req('h09, 32'he000_0009), wr_req('h09, 32'he111_0009), 0, '0, 0, '0);
    add_step(wr_req('h1a, 32'hf000_001a), wr_req('h0a, 32'hf111_000a), 0, '0, 0, '0);
    add_step(wr_req('h2b, 32'h9000_002b), wr_req('h0b, 32'h9111_000b), 0, '0, 0, '0);
    add_step(rd_req('h08), rd_req('h09), 1, 32'he111_0008, 1, 32'he111_0009);
    add_step(rd_req('h0a), rd_req('h0b), 1, 32'hf111_000a, 1, 32'h9111_000b);
    add_step(rd_req('h1a), rd_req('h2b), 1, 32'hf000_001a, 1, 32'h9000_002b);
    add_step(rd_req('h30), rd_req('h20), 1, 32'ha300_0030, 1, 32'h1111_0020);
    add_step(rd_req('h04), rd_req('h0c), 1, fill_word('h04), 1, fill_word('h0c));
    limit = 2 * (16 + NUMVROW) + NUMADDR / 2 + steps.size() + NRAND + 50;
    reset_sweep();
    for (int a = 0; a < NUMADDR; a += 2)
      run_step(step_t'{wr_req(a, fill_word(a)), wr_req(a + 1, fill_word(a + 1)),
                       1'b0, '0, 1'b0, '0});
    reset_sweep();                      // Identity map again while the preloaded words stay
    foreach (steps[i])
      run_step(steps[i]);
    random_phase();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, DUT.u_sva.fails);
    if (errors == 0 && DUT.u_sva.fails == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* mem2rw_top.f */
rtl/mem_cfg_pkg.sv
rtl/mem_types_pkg.sv
rtl/mem_array.sv
rtl/bank_map.sv
rtl/bank_datapath.sv
rtl/mem2rw_top.sv
tb/mem2rw_sva.sv
tb/mem2rw_tb.sv

/* Bender.yml */
package:
  name: mem2rw

sources:
  - rtl/mem_cfg_pkg.sv
  - rtl/mem_types_pkg.sv
  - rtl/mem_array.sv
  - rtl/bank_map.sv
  - rtl/bank_datapath.sv
  - rtl/mem2rw_top.sv
  - target: test
    files:
      - tb/mem2rw_sva.sv
      - tb/mem2rw_tb.sv
